// File: Bender.yml
package:
  name: glb

sources:
  - files:
      - hw/glbPkg.sv
      - hw/glbConfig.sv
      - hw/glbWritePort.sv
      - hw/glbBankArray.sv
      - hw/glbReadPort.sv
      - hw/glbTop.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/glbTb.sv

// File: flist.f
+incdir+test
hw/glbPkg.sv
hw/glbConfig.sv
hw/glbWritePort.sv
hw/glbBankArray.sv
hw/glbReadPort.sv
hw/glbTop.sv
test/glbTb.sv

// File: hw/glbBankArray.sv
/*
 * Four single-port SRAM banks with per-bank port selection.
 * A bank serves the owning port whose address falls in its slice.
 * Reads win over writes; a read is only allowed below the paired
 * write port's count. Read data returns one cycle after the grant.
 */
`timescale 1ns/100ps
`default_nettype none

module glbBankArray import glbPkg::*; (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  wire [NumWrPorts-1:0]                          wrReq,
    input  wire [NumWrPorts-1:0][LimitW-1:0]              wrAddr,
    input  wire [NumWrPorts-1:0][WordW-1:0]               wrData,
    input  wire [NumRdPorts-1:0]                          rdReq,
    input  wire [NumRdPorts-1:0][PortAddrW-1:0]           rdAddr,
    input  wire [NumBanks-1:0]                            bankWrEn,
    input  wire [NumBanks-1:0]                            bankWrOwner,
    input  wire [NumBanks-1:0]                            bankRdEn,
    input  wire [NumBanks-1:0]                            bankRdOwner,
    input  wire [NumBanks-1:0][PortAddrW-BankAddrW-1:0]   bankWrRelIdx,
    input  wire [NumBanks-1:0][PortAddrW-BankAddrW-1:0]   bankRdRelIdx,
    input  wire [NumRdPorts-1:0]                          rdPairWr,
    output logic [NumWrPorts-1:0]                         wrGrant,
    output logic [NumRdPorts-1:0]                         rdGrant,
    output logic [NumRdPorts-1:0]                         bankRdValid,
    output logic [NumRdPorts-1:0][WordW-1:0]              bankRdData
);

    localparam int BankSelW = $clog2(NumBanks);

    logic [NumBanks-1:0]                 bankRdHit;
    logic [NumBanks-1:0]                 bankWrHit;
    logic [NumBanks-1:0][WordW-1:0]      bankWord;
    logic [NumRdPorts-1:0][BankSelW-1:0] rdBankNext;
    logic [NumRdPorts-1:0][BankSelW-1:0] rdBankQ;

    // ====================
    // Banks
    // ====================
    for (genvar b = 0; b < NumBanks; b++) begin : gBank
        logic [WordW-1:0] mem [BankDepth];
        logic [WordW-1:0] rdWord;
        logic             rdOwn;
        logic             wrOwn;
        logic             rdSel;
        logic             wrSel;
        logic             rdSafe;

        assign rdOwn = bankRdOwner[b];
        assign wrOwn = bankWrOwner[b];
        assign rdSel = rdAddr[rdOwn][PortAddrW-1:BankAddrW] == bankRdRelIdx[b];
        assign wrSel = wrAddr[wrOwn][PortAddrW-1:BankAddrW] == bankWrRelIdx[b];
        // Read guard against the paired write count
        assign rdSafe = {1'b0, rdAddr[rdOwn]} < wrAddr[rdPairWr[rdOwn]];

        assign bankRdHit[b] = bankRdEn[b] && rdReq[rdOwn] && rdSel && rdSafe;
        assign bankWrHit[b] = bankWrEn[b] && wrReq[wrOwn] && wrSel && !bankRdHit[b];
        assign bankWord[b]  = rdWord;

        always_ff @(posedge clk) begin
            if (bankWrHit[b]) begin
                mem[wrAddr[wrOwn][BankAddrW-1:0]] <= wrData[wrOwn];
            end
            if (bankRdHit[b]) begin
                rdWord <= mem[rdAddr[rdOwn][BankAddrW-1:0]];
            end
        end

        // Single-port macro: a write port loses its bank to a read
        assert property (@(posedge clk) disable iff (!rst_n)
            (bankRdHit[b] && bankWrEn[b] && wrReq[wrOwn] && wrSel) |-> !wrGrant[wrOwn]);
    end

    // ====================
    // Grants and return path
    // ====================
    always_comb begin
        rdGrant    = '0;
        wrGrant    = '0;
        rdBankNext = rdBankQ;
        for (int b = 0; b < NumBanks; b++) begin
            if (bankRdHit[b]) begin
                rdGrant[bankRdOwner[b]]    = 1'b1;
                rdBankNext[bankRdOwner[b]] = BankSelW'(b);
            end
            if (bankWrHit[b]) begin
                wrGrant[bankWrOwner[b]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bankRdValid <= '0;
        end else begin
            bankRdValid <= rdGrant;
        end
    end

    always_ff @(posedge clk) begin
        rdBankQ <= rdBankNext;
    end

    for (genvar r = 0; r < NumRdPorts; r++) begin : gRdData
        assign bankRdData[r] = bankWord[rdBankQ[r]];
    end

endmodule

`default_nettype wire

// File: hw/glbConfig.sv
/*
 * Configuration table of the global buffer.
 * Takes one entry per cycle: bank ownership, a port limit, or start.
 * Derives each bank's position inside its owners' address spaces and
 * the write port that every read port follows.
 */
`timescale 1ns/100ps
`default_nettype none

module glbConfig import glbPkg::*; (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  wire                                           cfgValid,
    input  wire glbCfgKind_e                              cfgKind,
    input  wire [1:0]                                     cfgIdx,
    input  wire glbCfgWord_u                              cfgWord,
    output logic                                          running,
    output logic [NumWrPorts-1:0][LimitW-1:0]             wrLimit,
    output logic [NumRdPorts-1:0][LimitW-1:0]             rdLimit,
    output logic [NumBanks-1:0]                           bankWrEn,
    output logic [NumBanks-1:0]                           bankWrOwner,
    output logic [NumBanks-1:0]                           bankRdEn,
    output logic [NumBanks-1:0]                           bankRdOwner,
    output logic [NumBanks-1:0][PortAddrW-BankAddrW-1:0]  bankWrRelIdx,
    output logic [NumBanks-1:0][PortAddrW-BankAddrW-1:0]  bankRdRelIdx,
    output logic [NumRdPorts-1:0]                         rdPairWr
);

    logic pairConflict;

    // ====================
    // Table update
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running     <= 1'b0;
            wrLimit     <= '0;
            rdLimit     <= '0;
            bankWrEn    <= '0;
            bankWrOwner <= '0;
            bankRdEn    <= '0;
            bankRdOwner <= '0;
        end else if (cfgValid) begin
            // Any table change stops the ports until the next start
            running <= (cfgKind == CfgStart);
            if (cfgKind == CfgBank) begin
                bankWrEn[cfgIdx]    <= cfgWord.bankView.wrEn;
                bankWrOwner[cfgIdx] <= cfgWord.bankView.wrOwner;
                bankRdEn[cfgIdx]    <= cfgWord.bankView.rdEn;
                bankRdOwner[cfgIdx] <= cfgWord.bankView.rdOwner;
            end else if (cfgKind == CfgLimit) begin
                if (cfgIdx[1]) begin
                    rdLimit[cfgIdx[0]] <= cfgWord.limitView.addrMax;
                end else begin
                    wrLimit[cfgIdx[0]] <= cfgWord.limitView.addrMax;
                end
            end
        end
    end

    // ====================
    // Derived mapping
    // ====================
    // Relative index counts lower banks held by the same owner
    always_comb begin
        for (int b = 0; b < NumBanks; b++) begin
            bankWrRelIdx[b] = '0;
            bankRdRelIdx[b] = '0;
            for (int lo = 0; lo < b; lo++) begin
                if (bankWrEn[lo] && bankWrOwner[lo] == bankWrOwner[b]) begin
                    bankWrRelIdx[b] = bankWrRelIdx[b] + 1'b1;
                end
                if (bankRdEn[lo] && bankRdOwner[lo] == bankRdOwner[b]) begin
                    bankRdRelIdx[b] = bankRdRelIdx[b] + 1'b1;
                end
            end
        end
    end

    // Walk downward so the lowest owned bank decides the pairing
    always_comb begin
        rdPairWr = '0;
        for (int b = NumBanks - 1; b >= 0; b--) begin
            if (bankRdEn[b]) begin
                rdPairWr[bankRdOwner[b]] = bankWrOwner[b];
            end
        end
    end

    always_comb begin
        pairConflict = 1'b0;
        for (int b = 0; b < NumBanks; b++) begin
            if (bankRdEn[b] && (!bankWrEn[b] || bankWrOwner[b] != rdPairWr[bankRdOwner[b]])) begin
                pairConflict = 1'b1;
            end
        end
    end

    // A read port must follow exactly one write port once started
    assert property (@(posedge clk) disable iff (!rst_n)
        (cfgValid && cfgKind == CfgStart) |-> !pairConflict);

endmodule

`default_nettype wire

// File: hw/glbPkg.sv
/*
 * Shared sizes and configuration types for the banked global buffer.
 * Every RTL block imports this package; all geometry lives here.
 * A configuration word is decoded as a bank entry or a limit entry,
 * depending on the kind that travels with it.
 */
`default_nettype none

package glbPkg;

    // ====================
    // Geometry
    // ====================
    localparam int NumBanks   = 4;
    localparam int NumWrPorts = 2;
    localparam int NumRdPorts = 2;
    localparam int BankDepth  = 16;
    localparam int BankAddrW  = 4;
    localparam int PortAddrW  = 6;
    localparam int WordW      = 32;
    // Word count, 0 to 64
    localparam int LimitW     = 7;

    // ====================
    // Configuration
    // ====================
    typedef enum logic [1:0] {
        CfgBank,
        CfgLimit,
        CfgStart
    } glbCfgKind_e;

    typedef struct packed {
        logic       wrEn;
        logic       wrOwner;
        logic       rdEn;
        logic       rdOwner;
        logic [3:0] pad;
    } glbBankView_s;

    typedef struct packed {
        logic [LimitW-1:0] addrMax;
        logic              pad;
    } glbLimitView_s;

    // Bank view for CfgBank, limit view for CfgLimit
    typedef union packed {
        glbBankView_s  bankView;
        glbLimitView_s limitView;
    } glbCfgWord_u;

endpackage

`default_nettype wire

// File: hw/glbReadPort.sv
/*
 * One read stream of the global buffer.
 * Issues bank reads within a two-word credit, catches the returning
 * word in a two-entry buffer and presents it with valid/ready.
 * Done rises once the configured number of words has left.
 */
`timescale 1ns/100ps
`default_nettype none

module glbReadPort import glbPkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  running,
    input  wire [LimitW-1:0]     limit,
    input  wire                  restart,
    input  wire                  rdGrant,
    input  wire                  bankRdValid,
    input  wire [WordW-1:0]      bankRdData,
    input  wire                  rdReady,
    output logic                 rdReq,
    output logic [PortAddrW-1:0] rdAddr,
    output logic                 rdValid,
    output logic [WordW-1:0]     rdData,
    output logic                 done
);

    logic [LimitW-1:0] reqCnt;
    logic [LimitW-1:0] outCnt;
    logic [LimitW-1:0] nextOut;
    logic              inFlight;
    logic [1:0]        fill;
    logic              wrPtr;
    logic              rdPtr;
    logic [WordW-1:0]  buffer [2];
    logic              push;
    logic              pop;

    assign push    = bankRdValid;
    assign pop     = rdValid && rdReady;
    assign rdValid = (fill != 2'd0);
    assign rdData  = buffer[rdPtr];
    assign rdAddr  = reqCnt[PortAddrW-1:0];
    assign nextOut = outCnt + {{(LimitW-1){1'b0}}, pop};

    // Credit covers the SRAM stage plus the buffer
    assign rdReq = running && !done && !restart && (reqCnt < limit)
                   && (({1'b0, inFlight} + fill) < 2'd2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reqCnt   <= '0;
            outCnt   <= '0;
            inFlight <= 1'b0;
            fill     <= '0;
            wrPtr    <= 1'b0;
            rdPtr    <= 1'b0;
            done     <= 1'b0;
        end else if (restart) begin
            reqCnt   <= '0;
            outCnt   <= '0;
            inFlight <= 1'b0;
            fill     <= '0;
            wrPtr    <= 1'b0;
            rdPtr    <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (rdGrant) begin
                reqCnt <= reqCnt + 1'b1;
            end
            inFlight <= rdGrant;
            if (push) begin
                wrPtr <= !wrPtr;
            end
            if (pop) begin
                rdPtr <= !rdPtr;
            end
            fill   <= fill + {1'b0, push} - {1'b0, pop};
            outCnt <= nextOut;
            if (running && nextOut == limit) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wrPtr] <= bankRdData;
        end
    end

    // A granted word always finds room one cycle later
    assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (fill < 2'd2 || pop));

endmodule

`default_nettype wire

// File: hw/glbTop.sv
/*
 * Top level of the banked global buffer.
 * Two write streams fill four SRAM banks and two read streams drain
 * them in order. Restart and done are indexed write ports first,
 * then read ports.
 */
`timescale 1ns/100ps
`default_nettype none

module glbTop import glbPkg::*; (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  cfgValid,
    input  wire glbCfgKind_e                     cfgKind,
    input  wire [1:0]                            cfgIdx,
    input  wire glbCfgWord_u                     cfgWord,
    input  wire [NumWrPorts-1:0]                 wrValid,
    input  wire [NumWrPorts-1:0][WordW-1:0]      wrData,
    output logic [NumWrPorts-1:0]                wrReady,
    output logic [NumRdPorts-1:0]                rdValid,
    output logic [NumRdPorts-1:0][WordW-1:0]     rdData,
    input  wire [NumRdPorts-1:0]                 rdReady,
    input  wire [NumWrPorts+NumRdPorts-1:0]      portRestart,
    output logic [NumWrPorts+NumRdPorts-1:0]     portDone
);

    logic                                         running;
    logic [NumWrPorts-1:0][LimitW-1:0]            wrLimit;
    logic [NumRdPorts-1:0][LimitW-1:0]            rdLimit;
    logic [NumBanks-1:0]                          bankWrEn;
    logic [NumBanks-1:0]                          bankWrOwner;
    logic [NumBanks-1:0]                          bankRdEn;
    logic [NumBanks-1:0]                          bankRdOwner;
    logic [NumBanks-1:0][PortAddrW-BankAddrW-1:0] bankWrRelIdx;
    logic [NumBanks-1:0][PortAddrW-BankAddrW-1:0] bankRdRelIdx;
    logic [NumRdPorts-1:0]                        rdPairWr;
    logic [NumWrPorts-1:0]                        wrReq;
    logic [NumWrPorts-1:0]                        wrGrant;
    logic [NumWrPorts-1:0][LimitW-1:0]            wrAddr;
    logic [NumRdPorts-1:0]                        rdReq;
    logic [NumRdPorts-1:0]                        rdGrant;
    logic [NumRdPorts-1:0][PortAddrW-1:0]         rdAddr;
    logic [NumRdPorts-1:0]                        bankRdValid;
    logic [NumRdPorts-1:0][WordW-1:0]             bankRdData;

    glbConfig u_glbConfig (
        .clk, .rst_n, .cfgValid, .cfgKind, .cfgIdx, .cfgWord,
        .running, .wrLimit, .rdLimit,
        .bankWrEn, .bankWrOwner, .bankRdEn, .bankRdOwner,
        .bankWrRelIdx, .bankRdRelIdx, .rdPairWr
    );

    for (genvar p = 0; p < NumWrPorts; p++) begin : gWr
        glbWritePort u_glbWritePort (
            .clk, .rst_n, .running,
            .limit     (wrLimit[p]),
            .restart   (portRestart[p]),
            .wrValid   (wrValid[p]),
            .wrReady   (wrReady[p]),
            .bankGrant (wrGrant[p]),
            .wrAddr    (wrAddr[p]),
            .bankReq   (wrReq[p]),
            .done      (portDone[p])
        );
    end

    glbBankArray u_glbBankArray (
        .clk, .rst_n, .wrReq, .wrAddr, .wrData, .rdReq, .rdAddr,
        .bankWrEn, .bankWrOwner, .bankRdEn, .bankRdOwner,
        .bankWrRelIdx, .bankRdRelIdx, .rdPairWr,
        .wrGrant, .rdGrant, .bankRdValid, .bankRdData
    );

    for (genvar r = 0; r < NumRdPorts; r++) begin : gRd
        glbReadPort u_glbReadPort (
            .clk, .rst_n, .running,
            .limit       (rdLimit[r]),
            .restart     (portRestart[NumWrPorts+r]),
            .rdGrant     (rdGrant[r]),
            .bankRdValid (bankRdValid[r]),
            .bankRdData  (bankRdData[r]),
            .rdReady     (rdReady[r]),
            .rdReq       (rdReq[r]),
            .rdAddr      (rdAddr[r]),
            .rdValid     (rdValid[r]),
            .rdData      (rdData[r]),
            .done        (portDone[NumWrPorts+r])
        );
    end

endmodule

`default_nettype wire

// File: hw/glbWritePort.sv
/*
 * One write stream of the global buffer.
 * Keeps the port-relative address, asks the bank array for the bank
 * behind it and accepts a beat only when that bank is granted.
 * The address doubles as the count of words written so far.
 */
`timescale 1ns/100ps
`default_nettype none

module glbWritePort import glbPkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               running,
    input  wire [LimitW-1:0]  limit,
    input  wire               restart,
    input  wire               wrValid,
    output logic              wrReady,
    input  wire               bankGrant,
    output logic [LimitW-1:0] wrAddr,
    output logic              bankReq,
    output logic              done
);

    logic              fire;
    logic [LimitW-1:0] nextCount;

    // Only ask for the bank when a word is actually offered
    assign bankReq   = running && !done && !restart && wrValid && (wrAddr < limit);
    assign wrReady   = running && !done && bankGrant;
    assign fire      = wrValid && wrReady;
    assign nextCount = wrAddr + {{(LimitW-1){1'b0}}, fire};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrAddr <= '0;
            done   <= 1'b0;
        end else if (restart) begin
            wrAddr <= '0;
            done   <= 1'b0;
        end else begin
            wrAddr <= nextCount;
            // Limit of zero finishes on the first running cycle
            if (running && nextCount == limit) begin
                done <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        fire |=> wrAddr <= limit);

endmodule

`default_nettype wire

// File: test/glbRefModel.svh
/*
 * Reference model for the global buffer testbench.
 * Queues every accepted write word per write port. A read port expects
 * its paired write port's queue, cut off at its own limit.
 * Included inside the testbench module, after the package import.
 */
`ifndef GLB_REF_MODEL_SVH
`define GLB_REF_MODEL_SVH

// Accepted words, oldest first
logic [WordW-1:0] wrQueue [NumWrPorts][$];
int               rdIdx   [NumRdPorts];
int               rdPair  [NumRdPorts];
int               wrLim   [NumWrPorts];
int               rdLim   [NumRdPorts];

function automatic void pushWrite(input int p, input logic [WordW-1:0] word);
    wrQueue[p].push_back(word);
endfunction

function automatic void clearWritePort(input int p);
    wrQueue[p].delete();
endfunction

function automatic void clearReadPort(input int r);
    rdIdx[r] = 0;
endfunction

// A word is only available below the limit and behind the writer
function automatic void nextExpected(input int r, output logic [WordW-1:0] word,
                                     output logic avail);
    avail = (rdIdx[r] < rdLim[r]) && (rdIdx[r] < wrQueue[rdPair[r]].size());
    word  = avail ? wrQueue[rdPair[r]][rdIdx[r]] : '0;
    rdIdx[r]++;
endfunction

`endif

// File: test/glbTb.sv
/*
 * Testbench for the banked global buffer.
 * Loads random legal configurations, streams random words through both
 * write ports and checks every read beat against the reference model.
 * Covers reset state, limits, back-pressure, restart and reconfiguration.
 */
`timescale 1ns/100ps
`default_nettype none

module glbTb import glbPkg::*; ();

    localparam int ModeIdle    = 0;
    localparam int ModeHigh    = 1;
    localparam int ModeRandom  = 2;
    localparam int ModeStall   = 3;
    localparam int NumRuns     = 7;
    localparam int StallFactor = 16;
    // Every run moves at most 64 words on each of four ports
    localparam int WatchdogCycles = NumRuns * 4 * 64 * StallFactor + 4000;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  cfgValid;
    glbCfgKind_e                           cfgKind;
    logic [1:0]                            cfgIdx;
    glbCfgWord_u                           cfgWord;
    logic [NumWrPorts-1:0]                 wrValid;
    logic [NumWrPorts-1:0][WordW-1:0]      wrData;
    logic [NumWrPorts-1:0]                 wrReady;
    logic [NumRdPorts-1:0]                 rdValid;
    logic [NumRdPorts-1:0][WordW-1:0]      rdData;
    logic [NumRdPorts-1:0]                 rdReady;
    logic [NumWrPorts+NumRdPorts-1:0]      portRestart;
    logic [NumWrPorts+NumRdPorts-1:0]      portDone;

    int                                    seed;
    int                                    stimMode;
    logic [NumRdPorts-1:0]                 bpReady;
    logic [3:0]                            ownBits;
    logic                                  swap;
    string                                 curTest;
    int                                    testErrors;
    int                                    totalErrors;
    int                                    testsRun;
    int                                    testsFailed;
    logic [NumRdPorts-1:0]                 holdPrev;
    logic [NumRdPorts-1:0][WordW-1:0]      holdData;

    `include "glbRefModel.svh"

    glbTop u_glbTop (
        .clk, .rst_n, .cfgValid, .cfgKind, .cfgIdx, .cfgWord,
        .wrValid, .wrData, .wrReady, .rdValid, .rdData, .rdReady,
        .portRestart, .portDone
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired before all ports finished");
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic int randBelow(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // ====================
    // Stimulus
    // ====================
    always @(posedge clk) begin
        for (int p = 0; p < NumWrPorts; p++) begin
            case (stimMode)
                ModeHigh:              wrValid[p] <= 1'b1;
                ModeRandom, ModeStall: wrValid[p] <= (randBelow(4) != 0);
                default:               wrValid[p] <= 1'b0;
            endcase
            wrData[p] <= $random(seed);
        end
        for (int r = 0; r < NumRdPorts; r++) begin
            // Long runs of ready low in stall mode
            if (stimMode == ModeStall && randBelow(12) == 0) begin
                bpReady[r] = !bpReady[r];
            end
            case (stimMode)
                ModeHigh:   rdReady[r] <= 1'b1;
                ModeRandom: rdReady[r] <= (randBelow(4) != 0);
                ModeStall:  rdReady[r] <= bpReady[r];
                default:    rdReady[r] <= 1'b0;
            endcase
        end
    end

    // ====================
    // Monitor
    // ====================
    always @(negedge clk) begin
        logic [WordW-1:0] expWord;
        logic             avail;
        if (rst_n) begin
            for (int p = 0; p < NumWrPorts; p++) begin
                if (wrValid[p] && wrReady[p]) begin
                    pushWrite(p, wrData[p]);
                end
            end
            for (int r = 0; r < NumRdPorts; r++) begin
                if (holdPrev[r]) begin
                    assert (rdValid[r]) else begin
                        $display("Read port %0d dropped rdValid while stalled", r);
                        testErrors++;
                    end
                    assert (rdData[r] == holdData[r]) else begin
                        $display("MISMATCH %s: expected %08h actual %08h",
                                 curTest, holdData[r], rdData[r]);
                        testErrors++;
                    end
                end
                holdPrev[r] = rdValid[r] && !rdReady[r] && !portRestart[NumWrPorts+r];
                holdData[r] = rdData[r];
                if (rdValid[r] && rdReady[r] && !portRestart[NumWrPorts+r]) begin
                    nextExpected(r, expWord, avail);
                    assert (avail) else begin
                        $display("Read port %0d delivered a word past its limit or writer", r);
                        testErrors++;
                    end
                    if (avail) begin
                        assert (rdData[r] == expWord) else begin
                            $display("MISMATCH %s: expected %08h actual %08h",
                                     curTest, expWord, rdData[r]);
                            testErrors++;
                        end
                    end
                end
            end
            // Restarted ports replay from address 0
            for (int p = 0; p < NumWrPorts; p++) begin
                if (portRestart[p]) begin
                    clearWritePort(p);
                end
            end
            for (int r = 0; r < NumRdPorts; r++) begin
                if (portRestart[NumWrPorts+r]) begin
                    clearReadPort(r);
                end
            end
        end
    end

    // ====================
    // Sequencing helpers
    // ====================
    task automatic setMode(input int mode);
        @(negedge clk);
        stimMode = mode;
    endtask

    task automatic sendCfg(input glbCfgKind_e kind, input logic [1:0] idx,
                           input glbCfgWord_u word);
        @(posedge clk);
        cfgValid <= 1'b1;
        cfgKind  <= kind;
        cfgIdx   <= idx;
        cfgWord  <= word;
        @(posedge clk);
        cfgValid <= 1'b0;
    endtask

    task automatic pulseRestart(input logic [3:0] ports);
        @(posedge clk);
        portRestart <= ports;
        @(posedge clk);
        portRestart <= '0;
    endtask

    function automatic glbCfgWord_u bankEntry(input int b);
        glbCfgWord_u word;
        word                  = '0;
        word.bankView.wrEn    = 1'b1;
        word.bankView.wrOwner = ownBits[b];
        word.bankView.rdEn    = 1'b1;
        word.bankView.rdOwner = ownBits[b] ^ swap;
        return word;
    endfunction

    function automatic glbCfgWord_u limitEntry(input int count);
        glbCfgWord_u word;
        word                   = '0;
        word.limitView.addrMax = LimitW'(count);
        return word;
    endfunction

    // Read port r follows write port r^swap over the same banks
    task automatic loadConfig();
        int nb [NumWrPorts];
        @(negedge clk);
        swap = randBelow(2);
        do begin
            ownBits = randBelow(16);
        end while (ownBits == 4'h0 || ownBits == 4'hf);
        nb[0] = 0;
        nb[1] = 0;
        for (int b = 0; b < NumBanks; b++) begin
            nb[ownBits[b]]++;
        end
        for (int p = 0; p < NumWrPorts; p++) begin
            wrLim[p] = randBelow(BankDepth * nb[p] + 1);
        end
        for (int r = 0; r < NumRdPorts; r++) begin
            rdPair[r] = r ^ swap;
            rdLim[r]  = randBelow(wrLim[rdPair[r]] + 1);
        end
        for (int b = 0; b < NumBanks; b++) begin
            sendCfg(CfgBank, 2'(b), bankEntry(b));
        end
        for (int p = 0; p < NumWrPorts; p++) begin
            sendCfg(CfgLimit, 2'(p), limitEntry(wrLim[p]));
        end
        for (int r = 0; r < NumRdPorts; r++) begin
            sendCfg(CfgLimit, 2'(NumWrPorts + r), limitEntry(rdLim[r]));
        end
        pulseRestart(4'hf);
        sendCfg(CfgStart, 2'd0, '0);
    endtask

    task automatic waitAllDone();
        do begin
            @(negedge clk);
        end while (portDone != 4'hf);
    endtask

    task automatic checkCounts();
        for (int p = 0; p < NumWrPorts; p++) begin
            assert (wrQueue[p].size() == wrLim[p]) else begin
                $display("MISMATCH %s: expected %0d actual %0d",
                         curTest, wrLim[p], wrQueue[p].size());
                testErrors++;
            end
        end
        for (int r = 0; r < NumRdPorts; r++) begin
            assert (rdIdx[r] == rdLim[r]) else begin
                $display("MISMATCH %s: expected %0d actual %0d", curTest, rdLim[r], rdIdx[r]);
                testErrors++;
            end
        end
        setMode(ModeHigh);
        repeat (8) begin
            @(negedge clk);
            assert (wrReady == '0 && rdValid == '0 && portDone == 4'hf) else begin
                $display("A finished port moved data or lost its done flag");
                testErrors++;
            end
        end
        setMode(ModeIdle);
    endtask

    task automatic beginTest(input string name);
        curTest    = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        testsRun++;
        totalErrors += testErrors;
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("%-16s %s (%0d errors)", curTest, (testErrors == 0) ? "passed" : "failed",
                 testErrors);
    endtask

    task automatic runStream(input string name, input int mode);
        beginTest(name);
        loadConfig();
        setMode(mode);
        waitAllDone();
        checkCounts();
        endTest();
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        seed        = 62859;
        rst_n       = 1'b0;
        cfgValid    = 1'b0;
        cfgKind     = CfgBank;
        cfgIdx      = '0;
        cfgWord     = '0;
        wrValid     = '0;
        wrData      = '0;
        rdReady     = '0;
        portRestart = '0;
        stimMode    = ModeIdle;
        bpReady     = '1;
        holdPrev    = '0;
        holdData    = '0;
        testsRun    = 0;
        testsFailed = 0;
        totalErrors = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        beginTest("reset_state");
        setMode(ModeHigh);
        repeat (20) begin
            @(negedge clk);
            assert (wrReady == '0 && rdValid == '0 && portDone == '0) else begin
                $display("Ports became active before any start entry");
                testErrors++;
            end
        end
        setMode(ModeIdle);
        endTest();

        for (int i = 0; i < 3; i++) begin
            runStream($sformatf("integrity_%0d", i), ModeRandom);
        end
        for (int i = 0; i < 2; i++) begin
            runStream($sformatf("backpressure_%0d", i), ModeStall);
        end

        // Restart write port 0 together with its reader halfway through
        beginTest("restart");
        loadConfig();
        setMode(ModeRandom);
        while (wrQueue[0].size() < wrLim[0] / 2 + 1 && !portDone[0]) begin
            @(negedge clk);
        end
        pulseRestart(4'b0001 | (4'b0100 << swap));
        waitAllDone();
        checkCounts();
        endTest();

        beginTest("reconfig");
        loadConfig();
        setMode(ModeRandom);
        while (wrQueue[0].size() + wrQueue[1].size() < 4 && portDone != 4'hf) begin
            @(negedge clk);
        end
        sendCfg(CfgBank, 2'd0, bankEntry(0));
        repeat (12) begin
            @(negedge clk);
            assert (wrReady == '0) else begin
                $display("A write was accepted after a bank entry stopped the buffer");
                testErrors++;
            end
        end
        sendCfg(CfgStart, 2'd0, '0);
        waitAllDone();
        checkCounts();
        endTest();

        $display("Tests %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
        if (totalErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
